/* filelist.f */
verilog/dc_pkg.sv
verilog/dc_req_stage.sv
verilog/dc_tag_array.sv
verilog/dc_plru.sv
verilog/dc_hit_stage.sv
verilog/dc_directory.sv
tb/dc_directory_asserts.sv
tb/dc_directory_tb.sv

/* tb/dc_directory_tb.sv */
`timescale 1ns/1ps

module dc_directory_tb;

	localparam int NUM_RAND = 300;
	localparam int NUM_REQ = 400;
	localparam int NUM_FLUSH = 2;
	localparam int TIMEOUT_CYCLES = 1000 + NUM_REQ * 4 + 200 * NUM_FLUSH;

	logic clk;
	logic rst_n;
	logic req_valid;
	dc_pkg::dc_req_t req;
	logic rsp_valid;
	dc_pkg::dc_rsp_t rsp;
	logic flush_busy;
	logic [15:0] dropped_count;

	// Expected values are set together with the request and then staged
	// Responses pass through one more stage than flush_busy and dropped_count
	logic next_valid;
	logic mid_valid;
	logic exp_valid;
	dc_pkg::dc_rsp_t next_rsp;
	dc_pkg::dc_rsp_t mid_rsp;
	dc_pkg::dc_rsp_t exp_rsp;
	logic next_busy;
	logic exp_busy;
	logic [15:0] next_dropped;
	logic [15:0] exp_dropped;

	// Reference model of the directory
	logic [dc_pkg::TAG_W-1:0] m_tag [dc_pkg::SETS][dc_pkg::WAYS];
	logic m_valid [dc_pkg::SETS][dc_pkg::WAYS];
	logic m_root [dc_pkg::SETS];
	logic m_lo [dc_pkg::SETS];
	logic m_hi [dc_pkg::SETS];
	logic m_busy;
	logic [15:0] m_dropped;
	int expected_count;
	int seen_count;

	dc_directory dc_directory_inst (
		.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req(req),
		.rsp_valid(rsp_valid), .rsp(rsp), .flush_busy(flush_busy),
		.dropped_count(dropped_count)
	);

	bind dc_directory dc_directory_asserts asserts_inst (
		.clk(clk), .rst_n(rst_n), .rsp_valid(rsp_valid), .rsp(rsp),
		.flush_busy(flush_busy), .dropped_count(dropped_count),
		.exp_valid(dc_directory_tb.exp_valid), .exp_rsp(dc_directory_tb.exp_rsp),
		.exp_busy(dc_directory_tb.exp_busy), .exp_dropped(dc_directory_tb.exp_dropped)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Flush state changes at the edge that samples the request
	// The response comes one edge after that
	always @(posedge clk) begin
		mid_valid <= next_valid;
		mid_rsp <= next_rsp;
		exp_valid <= mid_valid;
		exp_rsp <= mid_rsp;
		exp_busy <= next_busy;
		exp_dropped <= next_dropped;
		if (rst_n && rsp_valid) begin
			seen_count <= seen_count + 1;
		end
	end

	// ================================================
	// Reference model
	// ================================================

	function automatic logic [31:0] make_addr(input int set_no, input int tag);
		make_addr = {dc_pkg::TAG_W'(tag), dc_pkg::INDEX_W'(set_no), dc_pkg::OFFSET_W'($urandom)};
	endfunction

	// A set bit on the walk from the root means the upper way of the pair
	function automatic int tree_victim(input int s);
		if (m_root[s]) begin
			return m_hi[s] ? 3 : 2;
		end
		return m_lo[s] ? 1 : 0;
	endfunction

	// Point every bit on the path away from the way just used
	task automatic touch_line(input int s, input int w);
		m_root[s] = (w < 2);
		if (w < 2) begin
			m_lo[s] = (w == 0);
		end else begin
			m_hi[s] = (w == 2);
		end
	endtask

	task automatic model_access(input dc_pkg::dc_op_t op, input logic [31:0] addr,
			output dc_pkg::dc_rsp_t r);
		int s;
		int hw;
		int fw;
		logic [dc_pkg::TAG_W-1:0] t;
		s = int'(addr[dc_pkg::OFFSET_W +: dc_pkg::INDEX_W]);
		t = addr[dc_pkg::ADDR_W-1 -: dc_pkg::TAG_W];
		hw = -1;
		fw = -1;
		for (int w = 0; w < dc_pkg::WAYS; w++) begin
			if (hw < 0 && m_valid[s][w] && m_tag[s][w] == t) hw = w;
			if (fw < 0 && !m_valid[s][w]) fw = w;
		end
		r = '0;
		r.op = op;
		r.index = dc_pkg::INDEX_W'(s);
		r.hit = (hw >= 0);
		if (hw >= 0) r.way = dc_pkg::WAY_W'(hw);
		case (op)
			dc_pkg::OP_LOOKUP: if (hw >= 0) touch_line(s, hw);
			dc_pkg::OP_FILL: begin
				if (hw < 0) begin
					// In a full set the tree names the line that goes
					if (fw < 0) begin
						fw = tree_victim(s);
						r.evicted_valid = 1'b1;
						r.evicted_tag = m_tag[s][fw];
					end
					hw = fw;
					m_tag[s][hw] = t;
					m_valid[s][hw] = 1'b1;
				end
				r.way = dc_pkg::WAY_W'(hw);
				touch_line(s, hw);
			end
			dc_pkg::OP_INVAL: if (hw >= 0) m_valid[s][hw] = 1'b0;
			default: ;
		endcase
	endtask

	// ================================================
	// Stimulus
	// ================================================

	// Drives one clock edge worth of inputs and expectations
	task automatic drive_cycle(input logic v, input dc_pkg::dc_op_t op, input logic [31:0] addr,
			input logic ev, input dc_pkg::dc_rsp_t er);
		@(posedge clk);
		req_valid <= v;
		req.op <= op;
		req.addr <= addr;
		next_valid <= ev;
		next_rsp <= er;
		next_busy <= m_busy;
		next_dropped <= m_dropped;
	endtask

	task automatic send(input dc_pkg::dc_op_t op, input logic [31:0] addr);
		dc_pkg::dc_rsp_t r;
		model_access(op, addr, r);
		expected_count++;
		drive_cycle(1'b1, op, addr, 1'b1, r);
	endtask

	task automatic idle(input int n);
		repeat (n) drive_cycle(1'b0, dc_pkg::OP_LOOKUP, '0, 1'b0, '0);
	endtask

	// Busy covers SETS edges after the flush and requests in that window are lost
	task automatic run_flush();
		dc_pkg::dc_rsp_t r;
		logic drop;
		r = '0;
		r.op = dc_pkg::OP_FLUSH;
		r.index = dc_pkg::INDEX_W'(dc_pkg::SETS - 1);
		m_busy = 1'b1;
		drive_cycle(1'b1, dc_pkg::OP_FLUSH, '0, 1'b0, r);
		for (int s = 0; s < dc_pkg::SETS; s++) begin
			m_root[s] = 1'b0;
			m_lo[s] = 1'b0;
			m_hi[s] = 1'b0;
			for (int w = 0; w < dc_pkg::WAYS; w++) m_valid[s][w] = 1'b0;
		end
		for (int k = 1; k <= dc_pkg::SETS; k++) begin
			// The last edge of the window also gets a dropped request
			drop = (k % 20 == 5) || (k == dc_pkg::SETS);
			if (k == dc_pkg::SETS) m_busy = 1'b0;
			if (drop && m_dropped != 16'hffff) m_dropped++;
			// The flush response is due one edge after the last walk step
			drive_cycle(drop, ($urandom % 2) ? dc_pkg::OP_FILL : dc_pkg::OP_LOOKUP,
				make_addr(10, k), k == dc_pkg::SETS - 1, r);
		end
		expected_count++;
	endtask

	initial begin
		int sel;
		int errors;
		int missing;
		void'($urandom(32'h42e8b878));
		for (int s = 0; s < dc_pkg::SETS; s++) begin
			m_root[s] = 1'b0;
			m_lo[s] = 1'b0;
			m_hi[s] = 1'b0;
			for (int w = 0; w < dc_pkg::WAYS; w++) begin
				m_valid[s][w] = 1'b0;
				m_tag[s][w] = '0;
			end
		end
		{m_busy, m_dropped, expected_count, seen_count} = '0;
		{next_valid, next_rsp, next_busy, next_dropped} = '0;
		{mid_valid, mid_rsp} = '0;
		{exp_valid, exp_rsp, exp_busy, exp_dropped} = '0;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		idle(2);
		// Lookups in an empty directory before free-way fills and a repeated fill
		for (int i = 0; i < 6; i++) send(dc_pkg::OP_LOOKUP, make_addr(i * 21, i + 1));
		send(dc_pkg::OP_FILL, make_addr(10, 100));
		send(dc_pkg::OP_FILL, make_addr(10, 101));
		send(dc_pkg::OP_LOOKUP, make_addr(10, 100));
		send(dc_pkg::OP_FILL, make_addr(10, 100));
		// Fill a set to the top and keep evicting
		for (int i = 0; i < 10; i++) send(dc_pkg::OP_FILL, make_addr(20, 200 + i));
		// A hit moves the next victim while invalidates leave the tree alone
		send(dc_pkg::OP_LOOKUP, make_addr(20, 208));
		send(dc_pkg::OP_FILL, make_addr(20, 300));
		send(dc_pkg::OP_INVAL, make_addr(20, 301));
		send(dc_pkg::OP_INVAL, make_addr(20, 209));
		send(dc_pkg::OP_FILL, make_addr(20, 302));
		send(dc_pkg::OP_FILL, make_addr(20, 303));
		send(dc_pkg::OP_INVAL, make_addr(10, 101));
		send(dc_pkg::OP_LOOKUP, make_addr(10, 101));
		send(dc_pkg::OP_INVAL, make_addr(10, 555));
		idle(3);
		run_flush();
		for (int i = 0; i < 4; i++) send(dc_pkg::OP_LOOKUP, make_addr(20, 300 + i));
		// Random traffic on three sets with more tags than ways
		for (int i = 0; i < NUM_RAND; i++) begin
			sel = $urandom % 8;
			if (sel == 7) begin
				idle(1);
			end else begin
				send(sel < 3 ? dc_pkg::OP_LOOKUP : (sel < 6 ? dc_pkg::OP_FILL : dc_pkg::OP_INVAL),
					make_addr((sel % 3 == 0) ? 3 : ((sel % 3 == 1) ? 64 : 127), $urandom % 7));
			end
		end
		run_flush();
		for (int i = 0; i < 7; i++) send(dc_pkg::OP_LOOKUP, make_addr(64, i));
		idle(4);
		errors = dc_directory_inst.asserts_inst.fail_count;
		missing = expected_count - seen_count;
		if (missing != 0) begin
			$display("Response count wrong: %0d expected, %0d seen", expected_count, seen_count);
		end
		$display("Assertion failures: %0d, missing responses: %0d", errors, missing);
		if (errors == 0 && missing == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog against a stuck run
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* tb/dc_directory_asserts.sv */
`timescale 1ns/1ps

module dc_directory_asserts (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                rsp_valid,
	input  dc_pkg::dc_rsp_t     rsp,
	input  logic                flush_busy,
	input  logic [15:0]         dropped_count,
	input  logic                exp_valid,
	input  dc_pkg::dc_rsp_t     exp_rsp,
	input  logic                exp_busy,
	input  logic [15:0]         exp_dropped
);

	int fail_count = 0;

	// ================================================
	// Response checks
	// ================================================

	// A response comes exactly in the cycle the model expects one
	a_rsp_valid: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid == exp_valid)
	else begin
		fail_count++;
		$error("MISMATCH at %0t: rsp_valid %b, expected %b", $time,
			$sampled(rsp_valid), $sampled(exp_valid));
	end

	a_rsp_op_index: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid |-> rsp.op == exp_rsp.op && rsp.index == exp_rsp.index)
	else begin
		fail_count++;
		$error("MISMATCH at %0t: op or index differs from the model", $time);
	end

	// Flush responses carry no hit information
	a_rsp_hit: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid && exp_rsp.op != dc_pkg::OP_FLUSH |-> rsp.hit == exp_rsp.hit)
	else begin
		fail_count++;
		$error("MISMATCH at %0t: hit %b, expected %b", $time,
			$sampled(rsp.hit), $sampled(exp_rsp.hit));
	end

	// The way only means something on a hit or for a fill
	a_rsp_way: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid && (exp_rsp.hit || exp_rsp.op == dc_pkg::OP_FILL) |-> rsp.way == exp_rsp.way)
	else begin
		fail_count++;
		$error("MISMATCH at %0t: way %0d, expected %0d", $time,
			$sampled(rsp.way), $sampled(exp_rsp.way));
	end

	a_rsp_evict: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid && exp_rsp.op == dc_pkg::OP_FILL |->
		rsp.evicted_valid == exp_rsp.evicted_valid &&
		(!exp_rsp.evicted_valid || rsp.evicted_tag == exp_rsp.evicted_tag))
	else begin
		fail_count++;
		$error("MISMATCH at %0t: evicted line differs from the model", $time);
	end

	// ================================================
	// Flush state
	// ================================================

	a_flush_busy: assert property (@(posedge clk) disable iff (!rst_n)
		flush_busy == exp_busy)
	else begin
		fail_count++;
		$error("MISMATCH at %0t: flush_busy %b, expected %b", $time,
			$sampled(flush_busy), $sampled(exp_busy));
	end

	a_dropped: assert property (@(posedge clk) disable iff (!rst_n)
		dropped_count == exp_dropped)
	else begin
		fail_count++;
		$error("MISMATCH at %0t: dropped_count %0d, expected %0d", $time,
			$sampled(dropped_count), $sampled(exp_dropped));
	end

endmodule

/* verilog/dc_directory.sv */
`timescale 1ns/1ps

module dc_directory (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            req_valid,
	input  dc_pkg::dc_req_t                 req,
	output logic                            rsp_valid,
	output dc_pkg::dc_rsp_t                 rsp,
	output logic                            flush_busy,
	output logic [15:0]                     dropped_count
);

	// ================================================
	// Interconnect
	// ================================================

	// Registered request and the index that both arrays capture with it
	dc_pkg::dc_ireq_t ireq;
	logic [dc_pkg::INDEX_W-1:0] rd_index;

	// Read data of the selected set
	dc_pkg::dc_way_tags_t rd_tags;
	logic [dc_pkg::WAYS-1:0] rd_valid;
	logic [dc_pkg::WAY_W-1:0] repl_way;

	// Tag array write and clear
	logic wr_en;
	logic [dc_pkg::WAY_W-1:0] wr_way;
	logic [dc_pkg::INDEX_W-1:0] wr_index;
	logic [dc_pkg::TAG_W-1:0] wr_tag;
	logic clr_en;
	logic [dc_pkg::WAY_W-1:0] clr_way;
	logic [dc_pkg::INDEX_W-1:0] clr_index;
	logic clr_set;

	// Replacement update
	logic touch_en;
	logic [dc_pkg::INDEX_W-1:0] touch_index;
	logic [dc_pkg::WAY_W-1:0] touch_way;

	// Request stage feeds both arrays and the hit stage
	dc_req_stage req_stage_inst (
		.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req(req),
		.ireq(ireq), .rd_index(rd_index), .flush_busy(flush_busy),
		.dropped_count(dropped_count)
	);

	dc_tag_array tag_array_inst (
		.clk(clk), .rst_n(rst_n), .rd_index(rd_index),
		.wr_en(wr_en), .wr_way(wr_way), .wr_index(wr_index), .wr_tag(wr_tag),
		.clr_en(clr_en), .clr_way(clr_way), .clr_index(clr_index), .clr_set(clr_set),
		.rd_tags(rd_tags), .rd_valid(rd_valid)
	);

	// Only a whole-set flush clears the tree, an invalidate does not
	dc_plru plru_inst (
		.clk(clk), .rst_n(rst_n), .rd_index(rd_index),
		.touch_en(touch_en), .touch_index(touch_index), .touch_way(touch_way),
		.clr_en(clr_set), .clr_index(clr_index), .repl_way(repl_way)
	);

	dc_hit_stage hit_stage_inst (
		.clk(clk), .rst_n(rst_n), .ireq(ireq),
		.rd_tags(rd_tags), .rd_valid(rd_valid), .repl_way(repl_way),
		.wr_en(wr_en), .wr_way(wr_way), .wr_index(wr_index), .wr_tag(wr_tag),
		.clr_en(clr_en), .clr_way(clr_way), .clr_index(clr_index), .clr_set(clr_set),
		.touch_en(touch_en), .touch_index(touch_index), .touch_way(touch_way),
		.rsp_valid(rsp_valid), .rsp(rsp)
	);

endmodule

/* verilog/dc_hit_stage.sv */
`timescale 1ns/1ps

module dc_hit_stage (
	input  logic                            clk,
	input  logic                            rst_n,
	input  dc_pkg::dc_ireq_t                ireq,
	input  dc_pkg::dc_way_tags_t            rd_tags,
	input  logic [dc_pkg::WAYS-1:0]         rd_valid,
	input  logic [dc_pkg::WAY_W-1:0]        repl_way,
	output logic                            wr_en,
	output logic [dc_pkg::WAY_W-1:0]        wr_way,
	output logic [dc_pkg::INDEX_W-1:0]      wr_index,
	output logic [dc_pkg::TAG_W-1:0]        wr_tag,
	output logic                            clr_en,
	output logic [dc_pkg::WAY_W-1:0]        clr_way,
	output logic [dc_pkg::INDEX_W-1:0]      clr_index,
	output logic                            clr_set,
	output logic                            touch_en,
	output logic [dc_pkg::INDEX_W-1:0]      touch_index,
	output logic [dc_pkg::WAY_W-1:0]        touch_way,
	output logic                            rsp_valid,
	output dc_pkg::dc_rsp_t                 rsp
);

	logic hit;
	logic [dc_pkg::WAY_W-1:0] hit_way;
	logic free;
	logic [dc_pkg::WAY_W-1:0] free_way;
	logic [dc_pkg::WAY_W-1:0] victim;
	logic [dc_pkg::WAY_W-1:0] fill_way;
	logic evict;
	dc_pkg::dc_rsp_t rsp_d;

	// ================================================
	// Tag compare and victim choice
	// ================================================

	// Scan from the top so the lowest matching or free way wins
	always_comb begin
		hit = 1'b0;
		hit_way = '0;
		free = 1'b0;
		free_way = '0;
		for (int w = dc_pkg::WAYS - 1; w >= 0; w--) begin
			if (rd_valid[w] && rd_tags[w] == ireq.tag) begin
				hit = 1'b1;
				hit_way = dc_pkg::WAY_W'(w);
			end
			if (!rd_valid[w]) begin
				free = 1'b1;
				free_way = dc_pkg::WAY_W'(w);
			end
		end
	end

	// An empty way beats the tree choice, so a full set is the only eviction
	assign victim = free ? free_way : repl_way;
	assign fill_way = hit ? hit_way : victim;
	assign evict = !hit && !free;

	// ================================================
	// Array actions and response
	// ================================================

	always_comb begin
		wr_en = 1'b0;
		wr_way = fill_way;
		wr_index = ireq.index;
		wr_tag = ireq.tag;
		clr_en = 1'b0;
		clr_way = hit_way;
		clr_index = ireq.index;
		clr_set = 1'b0;
		touch_en = 1'b0;
		touch_index = ireq.index;
		touch_way = hit_way;
		rsp_d.op = ireq.op;
		rsp_d.hit = hit;
		rsp_d.way = hit_way;
		rsp_d.evicted_valid = 1'b0;
		rsp_d.evicted_tag = '0;
		rsp_d.index = ireq.index;
		if (ireq.flush_set) begin
			// Flush step, the set is wiped and its tree returns to zero
			clr_set = 1'b1;
			rsp_d.hit = 1'b0;
			rsp_d.way = '0;
		end else if (ireq.valid) begin
			case (ireq.op)
				dc_pkg::OP_LOOKUP: touch_en = hit;
				dc_pkg::OP_FILL: begin
					// A fill that hits rewrites the same tag in place
					wr_en = 1'b1;
					touch_en = 1'b1;
					touch_way = fill_way;
					rsp_d.way = fill_way;
					rsp_d.evicted_valid = evict;
					rsp_d.evicted_tag = evict ? rd_tags[victim] : '0;
				end
				// Invalidate leaves the tree alone
				dc_pkg::OP_INVAL: clr_en = hit;
				default: ;
			endcase
		end
	end

	// Response appears one cycle after the request was registered
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= ireq.valid;
		end
	end

	always_ff @(posedge clk) begin
		rsp <= rsp_d;
	end

endmodule

/* verilog/dc_plru.sv */
`timescale 1ns/1ps

module dc_plru (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [dc_pkg::INDEX_W-1:0]      rd_index,
	input  logic                            touch_en,
	input  logic [dc_pkg::INDEX_W-1:0]      touch_index,
	input  logic [dc_pkg::WAY_W-1:0]        touch_way,
	input  logic                            clr_en,
	input  logic [dc_pkg::INDEX_W-1:0]      clr_index,
	output logic [dc_pkg::WAY_W-1:0]        repl_way
);

	// ================================================
	// Tree layout
	// ================================================

	// Bit 0 is the root, 0 points at ways 0-1 and 1 at ways 2-3
	// Bit 1 picks within ways 0-1, 0 means way 0
	// Bit 2 picks within ways 2-3, 0 means way 2

	logic [dc_pkg::PLRU_W-1:0] tree [dc_pkg::SETS];
	logic [dc_pkg::INDEX_W-1:0] rd_index_q;
	logic [dc_pkg::PLRU_W-1:0] cur;

	// Same registered read index scheme as the tag array
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_index_q <= '0;
		end else begin
			rd_index_q <= rd_index;
		end
	end

	// Follow the tree from the root to name the replacement way
	always_comb begin
		cur = tree[rd_index_q];
		if (cur[0]) begin
			repl_way = {1'b1, cur[2]};
		end else begin
			repl_way = {1'b0, cur[1]};
		end
	end

	// ================================================
	// Update
	// ================================================

	// A touch turns every bit on its path away from the touched way
	// Only the pair bit on the path changes, the other pair keeps its state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < dc_pkg::SETS; s++) begin
				tree[s] <= '0;
			end
		end else if (clr_en) begin
			// Flush step returns the set to its reset state
			tree[clr_index] <= '0;
		end else if (touch_en) begin
			tree[touch_index][0] <= ~touch_way[1];
			if (touch_way[1]) begin
				tree[touch_index][2] <= ~touch_way[0];
			end else begin
				tree[touch_index][1] <= ~touch_way[0];
			end
		end
	end

endmodule

/* verilog/dc_tag_array.sv */
`timescale 1ns/1ps

module dc_tag_array (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [dc_pkg::INDEX_W-1:0]      rd_index,
	input  logic                            wr_en,
	input  logic [dc_pkg::WAY_W-1:0]        wr_way,
	input  logic [dc_pkg::INDEX_W-1:0]      wr_index,
	input  logic [dc_pkg::TAG_W-1:0]        wr_tag,
	input  logic                            clr_en,
	input  logic [dc_pkg::WAY_W-1:0]        clr_way,
	input  logic [dc_pkg::INDEX_W-1:0]      clr_index,
	input  logic                            clr_set,
	output dc_pkg::dc_way_tags_t            rd_tags,
	output logic [dc_pkg::WAYS-1:0]         rd_valid
);

	// ================================================
	// Storage
	// ================================================

	// Tags of all ways in one flat memory, way selects the upper address bits
	logic [dc_pkg::TAG_W-1:0] tags [dc_pkg::WAYS * dc_pkg::SETS];

	// Valid bits live in flops so that reset and flush can clear them
	logic [dc_pkg::WAYS-1:0] valid [dc_pkg::SETS];

	// Read index captured at the edge the request is registered
	logic [dc_pkg::INDEX_W-1:0] rd_index_q;

	// ================================================
	// Write side
	// ================================================

	// Tag write for a fill, address is {way, set}
	always_ff @(posedge clk) begin
		if (wr_en) begin
			tags[{wr_way, wr_index}] <= wr_tag;
		end
	end

	// Valid bit update
	// A flush step clears the whole set, an invalidate clears one way
	// The hit stage never writes and clears the same line in one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < dc_pkg::SETS; s++) begin
				valid[s] <= '0;
			end
		end else begin
			if (clr_set) begin
				valid[clr_index] <= '0;
			end else if (clr_en) begin
				valid[clr_index][clr_way] <= 1'b0;
			end
			// Valid bit goes up at the same edge as the tag lands
			if (wr_en) begin
				valid[wr_index][wr_way] <= 1'b1;
			end
		end
	end

	// ================================================
	// Read side
	// ================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_index_q <= '0;
		end else begin
			rd_index_q <= rd_index;
		end
	end

	// Combinational read from the registered index
	// A write at the same edge is visible in the following cycle
	for (genvar w = 0; w < dc_pkg::WAYS; w++) begin : g_rd
		assign rd_tags[w] = tags[w * dc_pkg::SETS + int'(rd_index_q)];
		assign rd_valid[w] = valid[rd_index_q][w];
	end

endmodule

/* verilog/dc_req_stage.sv */
`timescale 1ns/1ps

module dc_req_stage (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            req_valid,
	input  dc_pkg::dc_req_t                 req,
	output dc_pkg::dc_ireq_t                ireq,
	output logic [dc_pkg::INDEX_W-1:0]      rd_index,
	output logic                            flush_busy,
	output logic [15:0]                     dropped_count
);

	// One extra bit so the counter can sit at SETS for the final busy cycle
	logic [dc_pkg::INDEX_W:0] flush_cnt;
	dc_pkg::dc_req_t req_split;
	logic walk_issue;
	logic walk_last;

	// Fill in set index and tag from the byte address
	always_comb begin
		req_split = req;
		req_split.index = req.addr[dc_pkg::OFFSET_W +: dc_pkg::INDEX_W];
		req_split.tag = req.addr[dc_pkg::OFFSET_W + dc_pkg::INDEX_W +: dc_pkg::TAG_W];
	end

	// Walk still has sets left to clear while the counter is below SETS
	assign walk_issue = flush_busy && (flush_cnt < dc_pkg::SETS);
	assign walk_last = (flush_cnt == dc_pkg::SETS - 1);

	// The arrays register this index at the same edge that ireq is loaded
	assign rd_index = flush_busy ? flush_cnt[dc_pkg::INDEX_W-1:0] : req_split.index;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ireq <= '0;
			flush_busy <= 1'b0;
			flush_cnt <= '0;
			dropped_count <= '0;
		end else begin
			// Idle unless something below issues a step
			ireq <= '0;
			if (flush_busy) begin
				if (walk_issue) begin
					// One set per cycle, the last step asks for the flush response
					ireq.valid <= walk_last;
					ireq.op <= dc_pkg::OP_FLUSH;
					ireq.index <= flush_cnt[dc_pkg::INDEX_W-1:0];
					ireq.flush_set <= 1'b1;
					flush_cnt <= flush_cnt + 1'b1;
				end else begin
					flush_busy <= 1'b0;
					flush_cnt <= '0;
				end
				// Anything arriving during the walk is lost, count saturates
				if (req_valid && dropped_count != 16'hffff) begin
					dropped_count <= dropped_count + 16'd1;
				end
			end else if (req_valid) begin
				if (req_split.op == dc_pkg::OP_FLUSH) begin
					// Set 0 is cleared straight away, the counter starts at 1
					flush_busy <= 1'b1;
					flush_cnt <= 1;
					ireq.op <= dc_pkg::OP_FLUSH;
					ireq.flush_set <= 1'b1;
				end else begin
					ireq.valid <= 1'b1;
					ireq.op <= req_split.op;
					ireq.index <= req_split.index;
					ireq.tag <= req_split.tag;
				end
			end
		end
	end

endmodule

/* verilog/dc_pkg.sv */
package dc_pkg;

	// ================================================
	// Directory geometry
	// ================================================

	// Byte address as seen by the load/store unit
	localparam int ADDR_W = 32;

	// Four ways of 128 sets, each line is 128 bytes
	localparam int WAYS = 4;
	localparam int SETS = 128;

	// Address split is tag | index | offset
	localparam int OFFSET_W = 7;
	localparam int INDEX_W = 7;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

	// Way number and per-set tree state for the pseudo-LRU
	localparam int WAY_W = 2;
	localparam int PLRU_W = WAYS - 1;

	// ================================================
	// Request and response types
	// ================================================

	typedef enum logic [1:0] {
		OP_LOOKUP = 2'd0,
		OP_FILL   = 2'd1,
		OP_INVAL  = 2'd2,
		OP_FLUSH  = 2'd3
	} dc_op_t;

	// External request; index and tag are derived from addr by the request stage
	typedef struct packed {
		dc_op_t                   op;
		logic [ADDR_W-1:0]        addr;
		logic [INDEX_W-1:0]       index;
		logic [TAG_W-1:0]         tag;
	} dc_req_t;

	// Registered request handed from the request stage to the hit stage
	// A flush walk step has flush_set high and only the last step has valid high
	typedef struct packed {
		logic                     valid;
		dc_op_t                   op;
		logic [INDEX_W-1:0]       index;
		logic [TAG_W-1:0]         tag;
		logic                     flush_set;
	} dc_ireq_t;

	// Response to the outside world, one per accepted request or flush
	typedef struct packed {
		dc_op_t                   op;
		logic                     hit;
		logic [WAY_W-1:0]         way;
		logic                     evicted_valid;
		logic [TAG_W-1:0]         evicted_tag;
		logic [INDEX_W-1:0]       index;
	} dc_rsp_t;

	// All tags of one set as read out of the tag array
	typedef logic [WAYS-1:0][TAG_W-1:0] dc_way_tags_t;

endpackage
